//--- sv32_config.svh
`ifndef SV32_CONFIG_SVH
`define SV32_CONFIG_SVH

// word and address width
`define MMU_XLEN 32

// page offset bits
`define MMU_PAGE_BITS 12

// one vpn level
`define MMU_VPN_BITS 10

// 32-bit physical space
`define MMU_PPN_BITS 20

`define MMU_TLB_ENTRIES 16

`endif

//--- mmu_pkg.sv
`default_nettype none
`include "sv32_config.svh"

package mmu_pkg;

   typedef logic [`MMU_XLEN-1:0] word_t;
   typedef logic [2*`MMU_VPN_BITS-1:0] vpn_t;
   typedef logic [`MMU_PPN_BITS-1:0] ppn_t;

   typedef enum logic {
      ACC_READ  = 1'b0,
      ACC_WRITE = 1'b1
   } access_e;

   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_e;

   // mcause encodings for page faults
   typedef enum logic [4:0] {
      CAUSE_NONE     = 5'd0,
      CAUSE_FETCH_PF = 5'd12,
      CAUSE_LOAD_PF  = 5'd13,
      CAUSE_STORE_PF = 5'd15
   } cause_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LEVEL1,
      ST_LEVEL2,
      ST_DATA,
      ST_RESPOND
   } walk_state_e;

   typedef enum logic [1:0] {
      PTE_NEXT,
      PTE_LEAF,
      PTE_FAULT
   } pte_verdict_e;

   typedef struct packed {
      logic                   en;
      access_e                access;
      word_t                  addr;
      word_t                  wdata;
      logic [`MMU_XLEN/8-1:0] wstrb;
   } core_req_t;

   typedef struct packed {
      logic  en;
      word_t data;
   } core_resp_t;

   // same layout as a port request
   typedef core_req_t bus_req_t;

   typedef struct packed {
      logic  en;
      word_t data;
   } bus_resp_t;

   typedef struct packed {
      logic   valid;
      cause_e cause;
      word_t  tval;
   } trap_t;

endpackage

`default_nettype wire

//--- tlb.sv
`timescale 1ns/1ps
`default_nettype none
`include "sv32_config.svh"

module tlb #(
   parameter int ENTRIES = `MMU_TLB_ENTRIES
) (
   input  wire logic          clk,
   input  wire logic          rstn,
   input  wire mmu_pkg::vpn_t lookup_vpn,
   output logic               hit,
   output mmu_pkg::ppn_t      hit_ppn,
   input  wire logic          fill,
   input  wire mmu_pkg::vpn_t fill_vpn,
   input  wire mmu_pkg::ppn_t fill_ppn,
   input  wire logic          flush
);

   localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

   logic [ENTRIES-1:0] valid;
   mmu_pkg::vpn_t      tag_q [ENTRIES];
   mmu_pkg::ppn_t      ppn_q [ENTRIES];

   logic               fill_present;
   logic [IDX_W-1:0]   fill_idx;
   logic               do_fill;

   ////////////////////
   // lookup
   ////////////////////

   // tags are unique, so at most one entry matches
   always_comb begin
      hit = 1'b0;
      hit_ppn = '0;
      for (int i = 0; i < ENTRIES; i++) begin
         if (valid[i] && tag_q[i] == lookup_vpn) begin
            hit = 1'b1;
            hit_ppn = ppn_q[i];
         end
      end
   end

   ////////////////////
   // fill slot
   ////////////////////

   // descending scan leaves the lowest free slot, entry 0 when full
   always_comb begin
      fill_present = 1'b0;
      fill_idx = '0;
      for (int i = ENTRIES - 1; i >= 0; i--) begin
         if (valid[i] && tag_q[i] == fill_vpn) begin
            fill_present = 1'b1;
         end
         if (!valid[i]) begin
            fill_idx = IDX_W'(i);
         end
      end
   end

   assign do_fill = fill && !fill_present;

   always_ff @(posedge clk) begin
      if (rstn) begin
         valid <= '0;
      end else if (flush) begin
         valid <= '0;
      end else if (do_fill) begin
         valid[fill_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_fill) begin
         tag_q[fill_idx] <= fill_vpn;
         ppn_q[fill_idx] <= fill_ppn;
      end
   end

   // flush is only taken when idle, fill only during a walk
   a_fill_flush: assert property (@(posedge clk) disable iff (rstn) !(fill && flush));

endmodule

`default_nettype wire

//--- pte_check.sv
`timescale 1ns/1ps
`default_nettype none
`include "sv32_config.svh"

module pte_check (
   input  wire mmu_pkg::word_t   pte,
   input  wire logic             level,
   input  wire mmu_pkg::word_t   vaddr,
   input  wire mmu_pkg::access_e access,
   input  wire logic             is_fetch,
   input  wire mmu_pkg::priv_e   cpu_mode,
   input  wire logic             sum,
   output mmu_pkg::pte_verdict_e verdict,
   output mmu_pkg::word_t        paddr,
   output mmu_pkg::word_t        next_addr
);

   localparam int PPN_LSB = 10;
   localparam int LOW_BITS = `MMU_VPN_BITS + `MMU_PAGE_BITS;

   logic          v, r, w, x, u, a, d;
   logic          pointer;
   logic          op_ok;
   logic          priv_ok;
   logic          misaligned;
   logic          fault;
   mmu_pkg::ppn_t ppn;

   assign v = pte[0];
   assign r = pte[1];
   assign w = pte[2];
   assign x = pte[3];
   assign u = pte[4];
   assign a = pte[6];
   assign d = pte[7];
   assign ppn = pte[PPN_LSB +: `MMU_PPN_BITS];

   // no r and no x means a pointer to the next table
   assign pointer = !r && !x;

   assign op_ok = is_fetch ? x : (access == mmu_pkg::ACC_WRITE) ? w : r;

   always_comb begin
      case (cpu_mode)
         mmu_pkg::PRIV_U: priv_ok = u;
         mmu_pkg::PRIV_S: priv_ok = !u || sum;
         default:         priv_ok = 1'b1;
      endcase
   end

   // superpage must be 4 MiB aligned
   assign misaligned = level && (ppn[`MMU_VPN_BITS-1:0] != '0);

   always_comb begin
      fault = !v || (w && !r);
      if (pointer) begin
         fault = fault || !level;
      end else begin
         fault = fault || !op_ok || !priv_ok || misaligned || !a
                 || (!is_fetch && access == mmu_pkg::ACC_WRITE && !d);
      end
   end

   always_comb begin
      if (fault) begin
         verdict = mmu_pkg::PTE_FAULT;
      end else if (pointer) begin
         verdict = mmu_pkg::PTE_NEXT;
      end else begin
         verdict = mmu_pkg::PTE_LEAF;
      end
   end

   // superpage keeps vpn0 from the virtual address
   assign paddr = level ? {ppn[`MMU_PPN_BITS-1:`MMU_VPN_BITS], vaddr[LOW_BITS-1:0]}
                        : {ppn, vaddr[`MMU_PAGE_BITS-1:0]};

   assign next_addr = {ppn, vaddr[LOW_BITS-1:`MMU_PAGE_BITS], 2'b00};

endmodule

`default_nettype wire

//--- sv32_translator.sv
`timescale 1ns/1ps
`default_nettype none
`include "sv32_config.svh"

module sv32_translator (
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire mmu_pkg::core_req_t    fetch_req,
   input  wire mmu_pkg::core_req_t    mem_req,
   input  wire mmu_pkg::word_t        satp,
   input  wire mmu_pkg::priv_e        cpu_mode,
   input  wire logic                  flush_tlb,
   output mmu_pkg::core_resp_t        fetch_resp,
   output mmu_pkg::core_resp_t        mem_resp,
   output mmu_pkg::trap_t             trap,
   output mmu_pkg::bus_req_t          bus_req,
   input  wire mmu_pkg::bus_resp_t    bus_resp,
   output mmu_pkg::vpn_t              tlb_lookup_vpn,
   input  wire logic                  tlb_hit,
   input  wire mmu_pkg::ppn_t         tlb_hit_ppn,
   output logic                       tlb_fill,
   output mmu_pkg::vpn_t              tlb_fill_vpn,
   output mmu_pkg::ppn_t              tlb_fill_ppn,
   output logic                       tlb_flush,
   output mmu_pkg::word_t             pte_word,
   output logic                       pte_level,
   output mmu_pkg::word_t             pte_vaddr,
   output mmu_pkg::access_e           pte_access,
   output logic                       pte_is_fetch,
   input  wire mmu_pkg::pte_verdict_e pte_verdict,
   input  wire mmu_pkg::word_t        pte_paddr,
   input  wire mmu_pkg::word_t        pte_next_addr
);

   mmu_pkg::walk_state_e state;
   mmu_pkg::core_req_t   sel_req;
   mmu_pkg::core_req_t   req_q;
   logic                 is_fetch_q;
   logic                 any_req;
   logic                 accept;
   logic                 bypass;
   logic                 walking;

   function automatic mmu_pkg::cause_e fault_cause(input logic fetch,
                                                   input mmu_pkg::access_e acc);
      if (fetch) begin
         return mmu_pkg::CAUSE_FETCH_PF;
      end
      return (acc == mmu_pkg::ACC_WRITE) ? mmu_pkg::CAUSE_STORE_PF : mmu_pkg::CAUSE_LOAD_PF;
   endfunction

   ////////////////////
   // port select
   ////////////////////

   // fetch wins a tie
   assign sel_req = fetch_req.en ? fetch_req : mem_req;
   assign any_req = fetch_req.en || mem_req.en;
   assign accept = (state == mmu_pkg::ST_IDLE) && any_req;
   assign bypass = !satp[`MMU_XLEN-1] || (cpu_mode == mmu_pkg::PRIV_M);
   assign walking = (state == mmu_pkg::ST_LEVEL1) || (state == mmu_pkg::ST_LEVEL2);

   assign tlb_lookup_vpn = sel_req.addr[`MMU_XLEN-1:`MMU_PAGE_BITS];
   assign tlb_flush = accept && flush_tlb;
   assign tlb_fill = walking && bus_resp.en && (pte_verdict == mmu_pkg::PTE_LEAF);
   assign tlb_fill_vpn = req_q.addr[`MMU_XLEN-1:`MMU_PAGE_BITS];
   assign tlb_fill_ppn = pte_paddr[`MMU_XLEN-1:`MMU_PAGE_BITS];

   // pte arrives straight off the bus
   assign pte_word = bus_resp.data;
   assign pte_level = (state == mmu_pkg::ST_LEVEL1);
   assign pte_vaddr = req_q.addr;
   assign pte_access = req_q.access;
   assign pte_is_fetch = is_fetch_q;

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= sel_req;
         is_fetch_q <= fetch_req.en;
      end
   end

   ////////////////////
   // main FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= mmu_pkg::ST_IDLE;
         bus_req <= '0;
         fetch_resp <= '0;
         mem_resp <= '0;
         trap <= '{valid: 1'b0, cause: mmu_pkg::CAUSE_NONE, tval: '0};
      end else begin
         bus_req.en <= 1'b0;
         case (state)
            mmu_pkg::ST_IDLE: begin
               if (any_req) begin
                  trap <= '{valid: 1'b0, cause: mmu_pkg::CAUSE_NONE, tval: '0};
                  if (flush_tlb) begin
                     fetch_resp <= '{en: fetch_req.en, data: '0};
                     mem_resp <= '{en: !fetch_req.en, data: '0};
                     state <= mmu_pkg::ST_RESPOND;
                  end else if (bypass) begin
                     bus_req <= sel_req;
                     state <= mmu_pkg::ST_DATA;
                  end else if (tlb_hit) begin
                     bus_req <= sel_req;
                     bus_req.addr <= {tlb_hit_ppn, sel_req.addr[`MMU_PAGE_BITS-1:0]};
                     state <= mmu_pkg::ST_DATA;
                  end else begin
                     // root table entry
                     bus_req <= '{en: 1'b1, access: mmu_pkg::ACC_READ,
                                  addr: {satp[`MMU_PPN_BITS-1:0],
                                         sel_req.addr[`MMU_XLEN-1 -: `MMU_VPN_BITS], 2'b00},
                                  wdata: '0, wstrb: '0};
                     state <= mmu_pkg::ST_LEVEL1;
                  end
               end
            end
            mmu_pkg::ST_LEVEL1, mmu_pkg::ST_LEVEL2: begin
               if (bus_resp.en) begin
                  case (pte_verdict)
                     mmu_pkg::PTE_NEXT: begin
                        bus_req <= '{en: 1'b1, access: mmu_pkg::ACC_READ,
                                     addr: pte_next_addr, wdata: '0, wstrb: '0};
                        state <= mmu_pkg::ST_LEVEL2;
                     end
                     mmu_pkg::PTE_LEAF: begin
                        bus_req <= req_q;
                        bus_req.en <= 1'b1;
                        bus_req.addr <= pte_paddr;
                        state <= mmu_pkg::ST_DATA;
                     end
                     default: begin
                        trap <= '{valid: 1'b1,
                                  cause: fault_cause(is_fetch_q, req_q.access),
                                  tval: req_q.addr};
                        fetch_resp <= '{en: is_fetch_q, data: '0};
                        mem_resp <= '{en: !is_fetch_q, data: '0};
                        state <= mmu_pkg::ST_RESPOND;
                     end
                  endcase
               end
            end
            mmu_pkg::ST_DATA: begin
               if (bus_resp.en) begin
                  fetch_resp <= '{en: is_fetch_q, data: bus_resp.data};
                  mem_resp <= '{en: !is_fetch_q, data: bus_resp.data};
                  state <= mmu_pkg::ST_RESPOND;
               end
            end
            default: begin
               fetch_resp.en <= 1'b0;
               mem_resp.en <= 1'b0;
               state <= mmu_pkg::ST_IDLE;
            end
         endcase
      end
   end

   a_one_resp: assert property (@(posedge clk) disable iff (rstn)
      !(fetch_resp.en && mem_resp.en));

   a_bus_pulse: assert property (@(posedge clk) disable iff (rstn)
      bus_req.en |=> !bus_req.en);

   // memory must not answer once the FSM has gone idle
   a_no_idle_resp: assert property (@(posedge clk) disable iff (rstn)
      (state == mmu_pkg::ST_IDLE) |-> !bus_resp.en);

endmodule

`default_nettype wire

//--- mmu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sv32_config.svh"

module mmu_top (
   input  wire logic               clk,
   input  wire logic               rstn,
   input  wire mmu_pkg::core_req_t fetch_req,
   input  wire mmu_pkg::core_req_t mem_req,
   input  wire mmu_pkg::word_t     satp,
   input  wire mmu_pkg::priv_e     cpu_mode,
   input  wire logic               sum,
   input  wire logic               flush_tlb,
   output mmu_pkg::core_resp_t     fetch_resp,
   output mmu_pkg::core_resp_t     mem_resp,
   output mmu_pkg::trap_t          trap,
   output mmu_pkg::bus_req_t       bus_req,
   input  wire mmu_pkg::bus_resp_t bus_resp
);

   mmu_pkg::vpn_t         tlb_lookup_vpn;
   logic                  tlb_hit;
   mmu_pkg::ppn_t         tlb_hit_ppn;
   logic                  tlb_fill;
   mmu_pkg::vpn_t         tlb_fill_vpn;
   mmu_pkg::ppn_t         tlb_fill_ppn;
   logic                  tlb_flush;

   mmu_pkg::word_t        pte_word;
   logic                  pte_level;
   mmu_pkg::word_t        pte_vaddr;
   mmu_pkg::access_e      pte_access;
   logic                  pte_is_fetch;
   mmu_pkg::pte_verdict_e pte_verdict;
   mmu_pkg::word_t        pte_paddr;
   mmu_pkg::word_t        pte_next_addr;

   sv32_translator translator_i (
      .clk           (clk),
      .rstn          (rstn),
      .fetch_req     (fetch_req),
      .mem_req       (mem_req),
      .satp          (satp),
      .cpu_mode      (cpu_mode),
      .flush_tlb     (flush_tlb),
      .fetch_resp    (fetch_resp),
      .mem_resp      (mem_resp),
      .trap          (trap),
      .bus_req       (bus_req),
      .bus_resp      (bus_resp),
      .tlb_lookup_vpn(tlb_lookup_vpn),
      .tlb_hit       (tlb_hit),
      .tlb_hit_ppn   (tlb_hit_ppn),
      .tlb_fill      (tlb_fill),
      .tlb_fill_vpn  (tlb_fill_vpn),
      .tlb_fill_ppn  (tlb_fill_ppn),
      .tlb_flush     (tlb_flush),
      .pte_word      (pte_word),
      .pte_level     (pte_level),
      .pte_vaddr     (pte_vaddr),
      .pte_access    (pte_access),
      .pte_is_fetch  (pte_is_fetch),
      .pte_verdict   (pte_verdict),
      .pte_paddr     (pte_paddr),
      .pte_next_addr (pte_next_addr)
   );

   tlb #(
      .ENTRIES(`MMU_TLB_ENTRIES)
   ) tlb_i (
      .clk       (clk),
      .rstn      (rstn),
      .lookup_vpn(tlb_lookup_vpn),
      .hit       (tlb_hit),
      .hit_ppn   (tlb_hit_ppn),
      .fill      (tlb_fill),
      .fill_vpn  (tlb_fill_vpn),
      .fill_ppn  (tlb_fill_ppn),
      .flush     (tlb_flush)
   );

   pte_check pte_check_i (
      .pte      (pte_word),
      .level    (pte_level),
      .vaddr    (pte_vaddr),
      .access   (pte_access),
      .is_fetch (pte_is_fetch),
      .cpu_mode (cpu_mode),
      .sum      (sum),
      .verdict  (pte_verdict),
      .paddr    (pte_paddr),
      .next_addr(pte_next_addr)
   );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "sv32_config.svh"

module tb_mem_model #(
   parameter int WORDS = 4096
) (
   input  wire logic               clk,
   input  wire logic               rstn,
   input  wire mmu_pkg::bus_req_t  bus_req,
   output mmu_pkg::bus_resp_t      bus_resp,
   output int                      access_count,
   output mmu_pkg::word_t          last_addr
);

   localparam int IDX_W = $clog2(WORDS);

   mmu_pkg::word_t     mem [WORDS];
   mmu_pkg::bus_resp_t resp_q = '0;
   int                 count_q = 0;
   mmu_pkg::word_t     addr_q = '0;
   mmu_pkg::word_t     rdata;
   logic               busy = 1'b0;
   int                 wait_cnt;
   logic [IDX_W-1:0]   idx;

   assign bus_resp = resp_q;
   assign access_count = count_q;
   assign last_addr = addr_q;

   // odd multiplier keeps every word distinct
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0003);
      end
   end

   // upper address bits alias onto the array
   always @(negedge clk) begin
      if (rstn) begin
         resp_q <= '0;
         busy <= 1'b0;
         count_q <= 0;
         addr_q <= '0;
      end else begin
         resp_q.en <= 1'b0;
         if (bus_req.en) begin
            idx = bus_req.addr[IDX_W+1:2];
            busy <= 1'b1;
            wait_cnt <= $urandom_range(4, 1);
            count_q <= count_q + 1;
            addr_q <= bus_req.addr;
            if (bus_req.access == mmu_pkg::ACC_WRITE) begin
               for (int b = 0; b < `MMU_XLEN / 8; b++) begin
                  if (bus_req.wstrb[b]) begin
                     mem[idx][8*b +: 8] = bus_req.wdata[8*b +: 8];
                  end
               end
               rdata <= '0;
            end else begin
               rdata <= mem[idx];
            end
         end else if (busy) begin
            if (wait_cnt == 1) begin
               resp_q <= '{en: 1'b1, data: rdata};
               busy <= 1'b0;
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_mmu.sv
`timescale 1ns/1ps
`default_nettype none
`include "sv32_config.svh"

module tb_mmu;

   localparam int TIMEOUT = 200;
   localparam mmu_pkg::word_t SATP_SV32 = 32'h8000_0001;
   localparam mmu_pkg::word_t ROOT_BASE = 32'h0000_1000;
   localparam mmu_pkg::word_t L2_BASE = 32'h0000_2000;
   localparam mmu_pkg::ppn_t L2_PPN = 20'h00002;
   localparam logic [7:0] F_V = 8'h01;
   localparam logic [7:0] F_R = 8'h02;
   localparam logic [7:0] F_W = 8'h04;
   localparam logic [7:0] F_X = 8'h08;
   localparam logic [7:0] F_U = 8'h10;
   localparam logic [7:0] F_A = 8'h40;
   localparam logic [7:0] F_D = 8'h80;
   localparam logic [7:0] F_RWAD = F_V | F_R | F_W | F_A | F_D;
   localparam mmu_pkg::trap_t TRAP_NONE = '{valid: 1'b0, cause: mmu_pkg::CAUSE_NONE, tval: '0};

   logic                clk = 1'b0;
   logic                rstn;
   mmu_pkg::core_req_t  fetch_req;
   mmu_pkg::core_req_t  mem_req;
   mmu_pkg::word_t      satp;
   mmu_pkg::priv_e      cpu_mode;
   logic                sum;
   logic                flush_tlb;
   mmu_pkg::core_resp_t fetch_resp;
   mmu_pkg::core_resp_t mem_resp;
   mmu_pkg::trap_t      trap;
   mmu_pkg::bus_req_t   bus_req;
   mmu_pkg::bus_resp_t  bus_resp;
   int                  access_count;
   mmu_pkg::word_t      last_addr;
   int                  checks;
   int                  errors;

   mmu_top dut_i (
      .clk       (clk),
      .rstn      (rstn),
      .fetch_req (fetch_req),
      .mem_req   (mem_req),
      .satp      (satp),
      .cpu_mode  (cpu_mode),
      .sum       (sum),
      .flush_tlb (flush_tlb),
      .fetch_resp(fetch_resp),
      .mem_resp  (mem_resp),
      .trap      (trap),
      .bus_req   (bus_req),
      .bus_resp  (bus_resp)
   );

   tb_mem_model mem_i (
      .clk         (clk),
      .rstn        (rstn),
      .bus_req     (bus_req),
      .bus_resp    (bus_resp),
      .access_count(access_count),
      .last_addr   (last_addr)
   );

   always #10 clk = ~clk;

   ////////////////////
   // helpers
   ////////////////////

   function automatic mmu_pkg::word_t make_va(input int vpn1, input int vpn0, input int off);
      return {vpn1[9:0], vpn0[9:0], off[11:0]};
   endfunction

   function automatic mmu_pkg::word_t make_pte(input mmu_pkg::ppn_t ppn, input logic [7:0] flags);
      return {2'b00, ppn, 2'b00, flags};
   endfunction

   task automatic put_word(input mmu_pkg::word_t addr, input mmu_pkg::word_t value);
      mem_i.mem[addr[13:2]] = value;
   endtask

   function automatic mmu_pkg::word_t get_word(input mmu_pkg::word_t addr);
      return mem_i.mem[addr[13:2]];
   endfunction

   task automatic set_root(input int vpn1, input mmu_pkg::word_t pte);
      put_word(ROOT_BASE + 32'(4 * vpn1), pte);
   endtask

   task automatic set_leaf(input int vpn0, input mmu_pkg::word_t pte);
      put_word(L2_BASE + 32'(4 * vpn0), pte);
   endtask

   task automatic check_word(input mmu_pkg::word_t got, input mmu_pkg::word_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_trap(input mmu_pkg::trap_t got, input mmu_pkg::trap_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s is valid %b cause %0d tval %h, expected %b %0d %h",
                  $time, what, got.valid, got.cause, got.tval, exp.valid, exp.cause, exp.tval);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         errors++;
         $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int err0);
      if (errors == err0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d error(s)", name, errors - err0);
      end
   endtask

   // one request on one port, held until its response pulse
   task automatic run_access(input logic fetch, input mmu_pkg::access_e acc,
                             input mmu_pkg::word_t va, input mmu_pkg::word_t wdata,
                             input logic flush, output mmu_pkg::word_t data,
                             output mmu_pkg::trap_t trap_seen, output int bus_count);
      mmu_pkg::core_req_t req;
      int                 start;
      int                 cycles;
      logic               done;
      req = '{en: 1'b1, access: acc, addr: va, wdata: wdata, wstrb: '1};
      start = access_count;
      if (fetch) begin
         fetch_req = req;
      end else begin
         mem_req = req;
      end
      flush_tlb = flush;
      done = 1'b0;
      cycles = 0;
      data = '0;
      trap_seen = TRAP_NONE;
      while (!done && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         if (fetch ? fetch_resp.en : mem_resp.en) begin
            done = 1'b1;
            data = fetch ? fetch_resp.data : mem_resp.data;
            trap_seen = trap;
         end
      end
      fetch_req = '0;
      mem_req = '0;
      flush_tlb = 1'b0;
      if (!done) begin
         errors++;
         $display("timeout: no response to the request at %h", va);
      end
      bus_count = access_count - start;
   endtask

   task automatic expect_ok(input logic fetch, input mmu_pkg::access_e acc,
                            input mmu_pkg::word_t va, input mmu_pkg::word_t pa,
                            input mmu_pkg::word_t wdata, input int exp_count, input string what);
      mmu_pkg::word_t exp_data;
      mmu_pkg::word_t data;
      mmu_pkg::trap_t t;
      int             n;
      exp_data = (acc == mmu_pkg::ACC_WRITE) ? '0 : get_word(pa);
      run_access(fetch, acc, va, wdata, 1'b0, data, t, n);
      check_word(data, exp_data, {what, " data"});
      check_word(last_addr, pa, {what, " physical address"});
      check_count(n, exp_count, {what, " bus accesses"});
      check_trap(t, TRAP_NONE, {what, " trap"});
      if (acc == mmu_pkg::ACC_WRITE) begin
         check_word(get_word(pa), wdata, {what, " stored word"});
      end
   endtask

   task automatic expect_fault(input logic fetch, input mmu_pkg::access_e acc,
                               input mmu_pkg::word_t va, input mmu_pkg::cause_e cause,
                               input int exp_count, input string what);
      mmu_pkg::word_t data;
      mmu_pkg::trap_t t;
      int             n;
      run_access(fetch, acc, va, 32'h1234_5678, 1'b0, data, t, n);
      check_word(data, '0, {what, " data"});
      check_trap(t, '{valid: 1'b1, cause: cause, tval: va}, {what, " trap"});
      check_count(n, exp_count, {what, " bus accesses"});
   endtask

   task automatic flush_all(input logic fetch, input string what);
      mmu_pkg::word_t data;
      mmu_pkg::trap_t t;
      int             n;
      run_access(fetch, mmu_pkg::ACC_READ, '0, '0, 1'b1, data, t, n);
      check_word(data, '0, {what, " data"});
      check_count(n, 0, {what, " bus accesses"});
   endtask

   ////////////////////
   // tests
   ////////////////////

   task automatic test_bare();
      int err0;
      err0 = errors;
      satp = '0;
      cpu_mode = mmu_pkg::PRIV_S;
      expect_ok(1'b0, mmu_pkg::ACC_WRITE, 32'h104, 32'h104, 32'hcafe_0104, 1, "bare write");
      expect_ok(1'b0, mmu_pkg::ACC_READ, 32'h104, 32'h104, '0, 1, "bare read");
      satp = SATP_SV32;
      cpu_mode = mmu_pkg::PRIV_M;
      expect_ok(1'b0, mmu_pkg::ACC_WRITE, 32'h208, 32'h208, 32'hbeef_0208, 1, "machine write");
      expect_ok(1'b0, mmu_pkg::ACC_READ, 32'h208, 32'h208, '0, 1, "machine read");
      cpu_mode = mmu_pkg::PRIV_S;
      report_test("bare and machine mode", err0);
   endtask

   task automatic test_4k();
      mmu_pkg::word_t va;
      mmu_pkg::word_t pa;
      int             err0;
      err0 = errors;
      va = make_va(1, 5, 12'h234);
      pa = {20'h12343, va[11:0]};
      set_root(1, make_pte(L2_PPN, F_V));
      set_leaf(5, make_pte(20'h12343, F_RWAD));
      flush_all(1'b0, "initial flush");
      expect_ok(1'b0, mmu_pkg::ACC_READ, va, pa, '0, 3, "first walk");
      expect_ok(1'b0, mmu_pkg::ACC_READ, va, pa, '0, 1, "tlb hit");
      flush_all(1'b0, "tlb flush");
      expect_ok(1'b0, mmu_pkg::ACC_READ, va, pa, '0, 3, "walk after flush");
      report_test("4 KiB translation", err0);
   endtask

   task automatic test_superpage();
      mmu_pkg::word_t va;
      mmu_pkg::word_t pa;
      int             err0;
      err0 = errors;
      va = make_va(2, 7, 12'h048);
      pa = {10'h155, va[21:0]};
      set_root(2, make_pte({10'h155, 10'h000}, F_RWAD | F_X));
      expect_ok(1'b0, mmu_pkg::ACC_READ, va, pa, '0, 2, "superpage read");
      va = make_va(3, 7, 12'h048);
      set_root(3, make_pte({10'h155, 10'h001}, F_RWAD | F_X));
      expect_fault(1'b0, mmu_pkg::ACC_READ, va, mmu_pkg::CAUSE_LOAD_PF, 1, "misaligned superpage");
      report_test("superpage", err0);
   endtask

   task automatic test_permissions();
      int err0;
      err0 = errors;
      set_leaf(8, make_pte(20'h60003, F_RWAD & ~F_V));
      set_leaf(9, make_pte(20'h61003, F_V | F_R | F_A | F_D));
      set_leaf(10, make_pte(20'h62003, F_RWAD & ~F_A));
      set_leaf(11, make_pte(20'h63003, F_RWAD & ~F_D));
      set_leaf(12, make_pte(20'h64003, F_RWAD));
      set_leaf(13, make_pte(20'h65003, F_RWAD | F_U));
      expect_fault(1'b0, mmu_pkg::ACC_READ, make_va(1, 8, 12'h10), mmu_pkg::CAUSE_LOAD_PF, 2,
                   "invalid pte");
      expect_fault(1'b0, mmu_pkg::ACC_WRITE, make_va(1, 9, 12'h14), mmu_pkg::CAUSE_STORE_PF, 2,
                   "write to read-only page");
      expect_fault(1'b0, mmu_pkg::ACC_READ, make_va(1, 10, 12'h18), mmu_pkg::CAUSE_LOAD_PF, 2,
                   "accessed bit clear");
      expect_fault(1'b0, mmu_pkg::ACC_WRITE, make_va(1, 11, 12'h1c), mmu_pkg::CAUSE_STORE_PF, 2,
                   "dirty bit clear");
      cpu_mode = mmu_pkg::PRIV_U;
      expect_fault(1'b0, mmu_pkg::ACC_READ, make_va(1, 12, 12'h20), mmu_pkg::CAUSE_LOAD_PF, 2,
                   "user on supervisor page");
      cpu_mode = mmu_pkg::PRIV_S;
      expect_fault(1'b0, mmu_pkg::ACC_READ, make_va(1, 13, 12'h24), mmu_pkg::CAUSE_LOAD_PF, 2,
                   "supervisor on user page");
      sum = 1'b1;
      expect_ok(1'b0, mmu_pkg::ACC_READ, make_va(1, 13, 12'h24), {20'h65003, 12'h024}, '0, 3,
                "supervisor on user page with sum");
      sum = 1'b0;
      report_test("permission faults", err0);
   endtask

   task automatic test_fetch();
      mmu_pkg::word_t va_f;
      mmu_pkg::word_t va_m;
      mmu_pkg::word_t exp_f;
      mmu_pkg::word_t exp_m;
      mmu_pkg::word_t got_f;
      mmu_pkg::word_t got_m;
      int             err0;
      int             start;
      int             cycles;
      int             f_at;
      int             m_at;
      err0 = errors;
      va_f = make_va(1, 14, 12'h0c0);
      va_m = make_va(1, 15, 12'h0d0);
      set_leaf(14, make_pte(20'h22223, F_V | F_R | F_X | F_A));
      set_leaf(15, make_pte(20'h33333, F_RWAD));
      set_leaf(16, make_pte(20'h44443, F_RWAD));
      exp_f = get_word({20'h22223, va_f[11:0]});
      exp_m = get_word({20'h33333, va_m[11:0]});
      // flush from the fetch port is answered on the fetch port
      flush_all(1'b1, "fetch port flush");
      start = access_count;
      got_f = '0;
      got_m = '0;
      f_at = 0;
      m_at = 0;
      cycles = 0;
      fetch_req = '{en: 1'b1, access: mmu_pkg::ACC_READ, addr: va_f, wdata: '0, wstrb: '0};
      mem_req = '{en: 1'b1, access: mmu_pkg::ACC_READ, addr: va_m, wdata: '0, wstrb: '0};
      while ((f_at == 0 || m_at == 0) && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         if (fetch_resp.en) begin
            f_at = cycles;
            got_f = fetch_resp.data;
            fetch_req = '0;
         end
         if (mem_resp.en) begin
            m_at = cycles;
            got_m = mem_resp.data;
            mem_req = '0;
         end
      end
      fetch_req = '0;
      mem_req = '0;
      if (f_at == 0 || m_at == 0) begin
         errors++;
         $display("timeout: fetch and data requests were not both answered");
      end else if (f_at >= m_at) begin
         errors++;
         $display("the data port was not answered after the fetch port");
      end
      check_word(got_f, exp_f, "fetch data");
      check_word(got_m, exp_m, "data port data");
      check_count(access_count - start, 6, "bus accesses of both walks");
      expect_fault(1'b1, mmu_pkg::ACC_READ, make_va(1, 16, 12'h0e0), mmu_pkg::CAUSE_FETCH_PF, 2,
                   "fetch without execute");
      report_test("fetch port and priority", err0);
   endtask

   task automatic test_replacement();
      mmu_pkg::word_t va [17];
      mmu_pkg::word_t pa [17];
      mmu_pkg::ppn_t  ppn;
      int             err0;
      err0 = errors;
      for (int i = 0; i < 17; i++) begin
         ppn = mmu_pkg::ppn_t'(32'h50003 + 4 * i);
         va[i] = make_va(1, 20 + i, 12'h040 + 4 * i);
         pa[i] = {ppn, va[i][11:0]};
         set_leaf(20 + i, make_pte(ppn, F_RWAD));
      end
      flush_all(1'b0, "replacement flush");
      for (int i = 0; i < 17; i++) begin
         expect_ok(1'b0, mmu_pkg::ACC_READ, va[i], pa[i], '0, 3, $sformatf("fill page %0d", i));
      end
      // seventeenth fill took entry 0
      expect_ok(1'b0, mmu_pkg::ACC_READ, va[0], pa[0], '0, 3, "evicted page");
      for (int i = 1; i < 16; i++) begin
         expect_ok(1'b0, mmu_pkg::ACC_READ, va[i], pa[i], '0, 1, $sformatf("resident page %0d", i));
      end
      report_test("tlb replacement", err0);
   endtask

   initial begin
      void'($urandom(32'he69d));
      rstn = 1'b1;
      fetch_req = '0;
      mem_req = '0;
      satp = '0;
      cpu_mode = mmu_pkg::PRIV_M;
      sum = 1'b0;
      flush_tlb = 1'b0;
      checks = 0;
      errors = 0;
      repeat (4) @(negedge clk);
      rstn = 1'b0;
      @(negedge clk);
      test_bare();
      test_4k();
      test_superpage();
      test_permissions();
      test_fetch();
      test_replacement();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
mmu_pkg.sv
tlb.sv
pte_check.sv
sv32_translator.sv
mmu_top.sv
tb_mem_model.sv
tb_mmu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu -f sim.f -o tb_mmu_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_mmu_sim 2>&1)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1
